// ==== bench/tb_accel_top.sv ====
/* Testbench for the inference endpoint. Sends frames into accel_top, predicts the reply
   beats and the statistics pin from the frame rules, and checks both with assertions. */
`timescale 1ns/1ps
`include "accel_macros.svh"

module tb_accel_top;

  localparam int          TIMEOUT_CYCLES = 2000;
  localparam logic [31:0] SEED = 32'd10;

  logic              gtx_clk_bufg;
  logic              rst_n;
  eth_pkg::rx_beat_t rx;
  eth_pkg::tx_beat_t tx;
  logic              tx_ready = 1'b0;
  logic              rx_stats_serial;

  // checker state
  int          cyc;
  logic [31:0] rng;
  logic [31:0] ready_rng;
  string       test_name;
  logic        checking;
  logic        rst_q;
  logic        tx_valid_q;
  logic        exp_ser_bit;
  logic [8:0]  exp_beat;

  // reply beats as {last, data}, and the cycle each reply should start
  logic [8:0]  exp_tx_q [$];
  int          rise_q [$];
  // serial bits paired with the cycle they are due
  int          ser_cyc_q [$];
  logic        ser_bit_q [$];

  accel_top u_accel_top (
    .gtx_clk_bufg    (gtx_clk_bufg),
    .rst_n           (rst_n),
    .rx              (rx),
    .tx              (tx),
    .tx_ready        (tx_ready),
    .rx_stats_serial (rx_stats_serial)
  );

  // 40 ns period
  always #20 gtx_clk_bufg = ~gtx_clk_bufg;

  // ----------------------------------------------------------
  // failure reporting
  // ----------------------------------------------------------
  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string what, input logic [63:0] expected,
                                input logic [63:0] actual);
    $display("ERROR test %s, %s: expected %0h, actual %0h", test_name, what, expected, actual);
    abort_run();
  endtask

  task automatic report_failure(input string what);
    $display("test %s: %s", test_name, what);
    abort_run();
  endtask

  // ----------------------------------------------------------
  // random numbers
  // ----------------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // ready low roughly one cycle in four, own generator state
  always @(posedge gtx_clk_bufg) begin
    ready_rng = xorshift(ready_rng);
    tx_ready <= (ready_rng[1:0] != 2'b00);
  end

  always @(posedge gtx_clk_bufg) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      report_failure("timeout, the run did not finish within the cycle limit");
    end
  end

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  task automatic push_reply(input logic [47:0] mac, input logic [31:0] ip, input logic result);
    logic [7:0]  bytes [$];
    logic [47:0] our_mac;
    logic [31:0] our_ip;
    logic [15:0] etype;
    logic [15:0] message;
    our_mac = `OUR_MAC_ADDRESS;
    our_ip  = `OUR_IP_ADDRESS;
    etype   = `ETHERTYPE_IPV4;
    // result zero extended, high byte goes first
    message = 16'(result);
    for (int i = 5; i >= 0; i--) bytes.push_back(mac[8 * i +: 8]);
    for (int i = 5; i >= 0; i--) bytes.push_back(our_mac[8 * i +: 8]);
    bytes.push_back(etype[15:8]);
    bytes.push_back(etype[7:0]);
    for (int i = 3; i >= 0; i--) bytes.push_back(our_ip[8 * i +: 8]);
    for (int i = 3; i >= 0; i--) bytes.push_back(ip[8 * i +: 8]);
    bytes.push_back(message[15:8]);
    bytes.push_back(message[7:0]);
    for (int i = 0; i < bytes.size(); i++) begin
      exp_tx_q.push_back({i == bytes.size() - 1, bytes[i]});
    end
  endtask

  task automatic expect_serial(input int at, input logic value);
    ser_cyc_q.push_back(at);
    ser_bit_q.push_back(value);
  endtask

  // start bit two cycles after the last beat, word msb first, stop bit, then idle
  task automatic push_stats(input int last_cyc, input int len, input logic accepted,
                            input logic is_short);
    logic [`RX_STATS_BITS-1:0] word;
    word = {14'(len), accepted, is_short};
    expect_serial(last_cyc + 2, 1'b1);
    for (int i = 0; i < `RX_STATS_BITS; i++) begin
      expect_serial(last_cyc + 3 + i, word[`RX_STATS_BITS - 1 - i]);
    end
    expect_serial(last_cyc + 3 + `RX_STATS_BITS, 1'b1);
    expect_serial(last_cyc + 4 + `RX_STATS_BITS, 1'b0);
  endtask

  // ----------------------------------------------------------
  // frame stimulus
  // ----------------------------------------------------------
  task automatic send_frame(input logic [47:0] dst_mac, input logic [15:0] etype,
                            input logic [31:0] dst_ip, input int len, input logic [1:0] xy);
    logic [7:0]  fb [0:63];
    logic [31:0] r;
    logic [47:0] src_mac;
    logic [31:0] src_ip;
    logic        is_short;
    logic        accepted;
    int          last_cyc;
    // random filler, requester fields come from it too
    for (int i = 0; i < 64; i++) begin
      r = next_rand();
      fb[i] = r[7:0];
    end
    for (int i = 0; i < 6; i++) begin
      fb[`OFS_DST_MAC + i] = dst_mac[8 * (5 - i) +: 8];
      src_mac[8 * (5 - i) +: 8] = fb[`OFS_SRC_MAC + i];
    end
    fb[`OFS_ETHERTYPE]     = etype[15:8];
    fb[`OFS_ETHERTYPE + 1] = etype[7:0];
    for (int i = 0; i < 4; i++) begin
      fb[`OFS_DST_IP + i] = dst_ip[8 * (3 - i) +: 8];
      src_ip[8 * (3 - i) +: 8] = fb[`OFS_SRC_IP + i];
    end
    // x in bit 0, y in bit 1
    fb[`OFS_PAYLOAD][1:0] = xy;
    is_short = len < `MIN_FRAME_BYTES;
    accepted = !is_short && dst_mac == `OUR_MAC_ADDRESS && etype == `ETHERTYPE_IPV4 &&
               dst_ip == `OUR_IP_ADDRESS;
    if (accepted) begin
      push_reply(src_mac, src_ip, xy[0] ^ xy[1]);
    end
    for (int i = 0; i < len; i++) begin
      @(posedge gtx_clk_bufg);
      rx.data  <= fb[i];
      rx.valid <= 1'b1;
      rx.last  <= (i == len - 1);
    end
    // the monitor sees the last beat one count later
    last_cyc = cyc + 1;
    push_stats(last_cyc, len, accepted, is_short);
    if (accepted) begin
      rise_q.push_back(last_cyc + 4);
    end
    @(posedge gtx_clk_bufg);
    rx <= '0;
  endtask

  task automatic wait_idle();
    while (exp_tx_q.size() != 0 || ser_cyc_q.size() != 0 || rise_q.size() != 0) begin
      @(posedge gtx_clk_bufg);
    end
    repeat (3) @(posedge gtx_clk_bufg);
  endtask

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  always @(posedge gtx_clk_bufg) begin
    rst_q      <= rst_n;
    tx_valid_q <= tx.valid;
    if (!rst_n) begin
      checking <= 1'b1;
    end
    if (checking) begin
      if (!rst_n || !rst_q) begin
        assert (!tx.valid && !rx_stats_serial)
          else report_failure("tx valid or stats pin high in or just after reset");
      end
      // idle level is 0 outside a queued sequence
      exp_ser_bit = 1'b0;
      if (ser_cyc_q.size() > 0 && ser_cyc_q[0] == cyc) begin
        exp_ser_bit = ser_bit_q.pop_front();
        void'(ser_cyc_q.pop_front());
      end
      assert (rx_stats_serial === exp_ser_bit)
        else value_mismatch("stats serial bit", exp_ser_bit, rx_stats_serial);
      if (tx.valid && !tx_valid_q) begin
        assert (rise_q.size() > 0) else report_failure("tx valid rose with no reply due");
        assert (rise_q[0] == cyc) else value_mismatch("tx valid rise cycle", rise_q[0], cyc);
        void'(rise_q.pop_front());
      end
      if (tx.valid && tx_ready) begin
        assert (exp_tx_q.size() > 0) else report_failure("more tx transfers than expected");
        exp_beat = exp_tx_q.pop_front();
        assert (tx.data === exp_beat[7:0]) else value_mismatch("tx data", exp_beat[7:0], tx.data);
        assert (tx.last === exp_beat[8]) else value_mismatch("tx last", exp_beat[8], tx.last);
      end
    end
  end

  // beat held while stalled
  tx_hold: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    (tx.valid && !tx_ready) |=> (tx.valid && $stable(tx.data) && $stable(tx.last)))
    else report_failure("tx beat changed or dropped while stalled");

  tx_last_valid: assert property (@(posedge gtx_clk_bufg) disable iff (!rst_n)
    tx.last |-> tx.valid)
    else report_failure("tx last set without tx valid");

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin
    logic [31:0] r;
    int          len;
    gtx_clk_bufg = 1'b0;
    rst_n        = 1'b0;
    rx           = '0;
    rng          = SEED;
    ready_rng    = SEED;
    cyc          = 0;
    checking     = 1'b0;
    rst_q        = 1'b0;
    tx_valid_q   = 1'b0;
    test_name    = "reset";
    repeat (10) @(posedge gtx_clk_bufg);
    rst_n <= 1'b1;
    repeat (5) @(posedge gtx_clk_bufg);

    // all four input pairs
    for (int xy = 0; xy < 4; xy++) begin
      test_name = $sformatf("xor x=%0d y=%0d", xy & 1, xy >> 1);
      r = next_rand();
      len = `MIN_FRAME_BYTES + int'(r % 23);
      send_frame(`OUR_MAC_ADDRESS, `ETHERTYPE_IPV4, `OUR_IP_ADDRESS, len, 2'(xy));
      wait_idle();
    end

    // frames that must be dropped
    test_name = "wrong mac";
    send_frame(`OUR_MAC_ADDRESS ^ 48'h1, `ETHERTYPE_IPV4, `OUR_IP_ADDRESS, 40, 2'b01);
    wait_idle();
    test_name = "wrong ethertype";
    send_frame(`OUR_MAC_ADDRESS, 16'h86dd, `OUR_IP_ADDRESS, 40, 2'b01);
    wait_idle();
    test_name = "wrong ip";
    send_frame(`OUR_MAC_ADDRESS, `ETHERTYPE_IPV4, `OUR_IP_ADDRESS ^ 32'h100, 40, 2'b10);
    wait_idle();
    test_name = "short frame";
    send_frame(`OUR_MAC_ADDRESS, `ETHERTYPE_IPV4, `OUR_IP_ADDRESS, 37, 2'b01);
    wait_idle();
    send_frame(`OUR_MAC_ADDRESS, `ETHERTYPE_IPV4, `OUR_IP_ADDRESS, 20, 2'b10);
    wait_idle();

    // random inputs and lengths under random stalls
    for (int n = 0; n < 4; n++) begin
      test_name = $sformatf("random stall %0d", n);
      r = next_rand();
      len = `MIN_FRAME_BYTES + int'(r % 23);
      send_frame(`OUR_MAC_ADDRESS, `ETHERTYPE_IPV4, `OUR_IP_ADDRESS, len, r[9:8]);
      wait_idle();
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_accel_top \
  -f sources.f --Mdir obj_dir -o tb_accel_top \
  && ./obj_dir/tb_accel_top | tee /dev/stderr | grep -qx "Simulation completed successfully" \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }

// ==== sources.f ====
+incdir+verilog
verilog/eth_pkg.sv
verilog/accel_pkg.sv
verilog/frame_parser.sv
verilog/xor_net.sv
verilog/frame_builder.sv
verilog/stats_serializer.sv
verilog/accel_top.sv
bench/tb_accel_top.sv

// ==== verilog/accel_macros.svh ====
/* Addresses, frame offsets, widths and network weights for the inference endpoint.
   Include wherever one of these constants is needed. */
`ifndef ACCEL_MACROS_SVH
`define ACCEL_MACROS_SVH

// accelerator identity
`define OUR_MAC_ADDRESS 48'h08_00_00_35_0a_00
`define OUR_IP_ADDRESS 32'h02_08_01_01
`define ETHERTYPE_IPV4 16'h0800

// byte offsets within a received frame
`define OFS_DST_MAC 0
`define OFS_SRC_MAC 6
`define OFS_ETHERTYPE 12
`define OFS_SRC_IP 26
`define OFS_DST_IP 30
`define OFS_PAYLOAD 34

// lengths and widths
`define USER_DATA_BYTES 4
`define MIN_FRAME_BYTES 38
`define REPLY_BYTES 24
`define MESSAGE_BITS 10
`define RX_STATS_BITS 16
`define LEN_BITS 14

// network weights and biases, 6 bit signed
`define W_IN 6'sd2
`define W_HID 6'sd2
`define B_OR (-6'sd1)
`define B_NAND 6'sd3
`define B_OUT (-6'sd3)

`endif

// ==== verilog/accel_pkg.sv ====
/* Inference types passed between the parser, the network and the reply builder.
   The requester addresses ride along so the reply can be addressed. */
package accel_pkg;

  // request from the parser, two input bits plus requester
  typedef struct packed {
    logic              x;
    logic              y;
    eth_pkg::ip_addr_t  ip;
    eth_pkg::mac_addr_t mac;
  } infer_req_t;

  // network result with the same requester
  typedef struct packed {
    logic              result;
    eth_pkg::ip_addr_t  ip;
    eth_pkg::mac_addr_t mac;
  } infer_res_t;

endpackage

// ==== verilog/accel_top.sv ====
/* Top level of the inference endpoint. Receive stream in, reply stream out,
   plus the serial statistics pin; all on gtx_clk_bufg. */
`timescale 1ns/1ps

module accel_top (
  input  logic              gtx_clk_bufg,
  input  logic              rst_n,
  input  eth_pkg::rx_beat_t rx,
  output eth_pkg::tx_beat_t tx,
  input  logic              tx_ready,
  output logic              rx_stats_serial
);

  // parser to network
  logic                  req_valid;
  accel_pkg::infer_req_t req;

  // network to builder
  logic                  res_valid;
  accel_pkg::infer_res_t res;

  // parser to serialiser
  logic                  stats_valid;
  eth_pkg::rx_stats_t    stats;

  // ----------------------------------------------------------
  // receive path
  // ----------------------------------------------------------
  frame_parser u_frame_parser (
    .gtx_clk_bufg (gtx_clk_bufg),
    .rst_n        (rst_n),
    .rx           (rx),
    .req_valid    (req_valid),
    .req          (req),
    .stats_valid  (stats_valid),
    .stats        (stats)
  );

  stats_serializer u_stats_serializer (
    .gtx_clk_bufg    (gtx_clk_bufg),
    .rst_n           (rst_n),
    .stats_valid     (stats_valid),
    .stats           (stats),
    .rx_stats_serial (rx_stats_serial)
  );

  // ----------------------------------------------------------
  // inference and reply
  // ----------------------------------------------------------
  xor_net u_xor_net (
    .gtx_clk_bufg (gtx_clk_bufg),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .req          (req),
    .res_valid    (res_valid),
    .res          (res)
  );

  frame_builder u_frame_builder (
    .gtx_clk_bufg (gtx_clk_bufg),
    .rst_n        (rst_n),
    .res_valid    (res_valid),
    .res          (res),
    .tx           (tx),
    .tx_ready     (tx_ready)
  );

endmodule

// ==== verilog/eth_pkg.sv ====
/* Frame level types: addresses, stream beats and the receive statistics word.
   Referenced by scoped name from every block that touches the byte streams. */
`include "accel_macros.svh"

package eth_pkg;

  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;

  // receive beat, no ready since the parser always accepts
  typedef struct packed {
    logic [7:0] data;
    logic       valid;
    logic       last;
  } rx_beat_t;

  // transmit beat, paired with tx_ready from outside
  typedef struct packed {
    logic [7:0] data;
    logic       valid;
    logic       last;
  } tx_beat_t;

  // per frame statistics, shifted out msb first
  typedef struct packed {
    logic [`LEN_BITS-1:0] len;
    logic                 accepted;
    logic                 is_short;
  } rx_stats_t;

endpackage

// ==== verilog/frame_builder.sv ====
/* Reply frame builder. Latches a result when idle and streams REPLY_BYTES beats,
   advancing one byte per transfer; results arriving mid reply are dropped. */
`timescale 1ns/1ps
`include "accel_macros.svh"

module frame_builder (
  input  logic                  gtx_clk_bufg,
  input  logic                  rst_n,
  input  logic                  res_valid,
  input  accel_pkg::infer_res_t res,
  output eth_pkg::tx_beat_t     tx,
  input  logic                  tx_ready
);

  logic                        busy;
  logic [4:0]                  idx;
  logic                        at_end;
  accel_pkg::infer_res_t       res_q;
  logic [`MESSAGE_BITS-1:0]    message;
  logic [`REPLY_BYTES*8-1:0]   reply;

  // ----------------------------------------------------------
  // reply layout, first byte in the top bits
  // ----------------------------------------------------------
  assign message = {{(`MESSAGE_BITS - 1){1'b0}}, res_q.result};

  assign reply = {
    res_q.mac,
    `OUR_MAC_ADDRESS,
    `ETHERTYPE_IPV4,
    `OUR_IP_ADDRESS,
    res_q.ip,
    {(16 - `MESSAGE_BITS){1'b0}},
    message
  };

  assign at_end = idx == 5'(`REPLY_BYTES - 1);

  // ----------------------------------------------------------
  // byte index and busy flag
  // ----------------------------------------------------------
  always_ff @(posedge gtx_clk_bufg) begin
    if (!rst_n) begin
      busy <= 1'b0;
      idx  <= '0;
    end else if (!busy) begin
      if (res_valid) begin
        busy <= 1'b1;
        idx  <= '0;
      end
    end else if (tx_ready) begin
      // transfer this cycle
      if (at_end) begin
        busy <= 1'b0;
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

  // result held for the whole reply
  always_ff @(posedge gtx_clk_bufg) begin
    if (!busy && res_valid) begin
      res_q <= res;
    end
  end

  // outputs come straight from registers, so they hold under stall
  assign tx.valid = busy;
  assign tx.last  = busy && at_end;
  assign tx.data  = reply[8 * (`REPLY_BYTES - 1 - int'(idx)) +: 8];

endmodule

// ==== verilog/frame_parser.sv ====
/* Receive side parser. Counts bytes, filters on MAC, ethertype and IP, and on the
   last beat issues an inference request and a statistics word one cycle later. */
`timescale 1ns/1ps
`include "accel_macros.svh"

module frame_parser (
  input  logic                gtx_clk_bufg,
  input  logic                rst_n,
  input  eth_pkg::rx_beat_t   rx,
  output logic                req_valid,
  output accel_pkg::infer_req_t req,
  output logic                stats_valid,
  output eth_pkg::rx_stats_t  stats
);

  logic [`LEN_BITS-1:0] byte_cnt;
  logic [`LEN_BITS-1:0] len_now;
  int                   pos;
  logic                 chk;
  logic [7:0]           exp_byte;
  logic                 hdr_ok;
  logic                 hdr_ok_now;
  logic                 accept_now;
  logic                 short_now;

  // captured requester fields and input bits
  eth_pkg::mac_addr_t   src_mac;
  eth_pkg::ip_addr_t    src_ip;
  logic                 x_bit;
  logic                 y_bit;

  // ----------------------------------------------------------
  // expected byte at the current offset
  // ----------------------------------------------------------
  always_comb begin
    pos = int'(byte_cnt);
    chk = 1'b0;
    exp_byte = 8'h00;
    if (pos < `OFS_DST_MAC + 6) begin
      // destination mac, msb first
      chk = 1'b1;
      exp_byte = 8'(`OUR_MAC_ADDRESS >> (8 * (`OFS_DST_MAC + 5 - pos)));
    end else if (pos >= `OFS_ETHERTYPE && pos < `OFS_ETHERTYPE + 2) begin
      chk = 1'b1;
      exp_byte = 8'(`ETHERTYPE_IPV4 >> (8 * (`OFS_ETHERTYPE + 1 - pos)));
    end else if (pos >= `OFS_DST_IP && pos < `OFS_DST_IP + 4) begin
      chk = 1'b1;
      exp_byte = 8'(`OUR_IP_ADDRESS >> (8 * (`OFS_DST_IP + 3 - pos)));
    end
  end

  // running match, restarted on the first byte of each frame
  assign hdr_ok_now = ((pos == 0) || hdr_ok) && !(chk && (rx.data != exp_byte));

  // length including this beat, saturating
  assign len_now = (&byte_cnt) ? byte_cnt : byte_cnt + 1'b1;

  assign short_now  = int'(len_now) < `MIN_FRAME_BYTES;
  assign accept_now = hdr_ok_now && !short_now;

  // ----------------------------------------------------------
  // byte counter and control
  // ----------------------------------------------------------
  always_ff @(posedge gtx_clk_bufg) begin
    if (!rst_n) begin
      byte_cnt    <= '0;
      hdr_ok      <= 1'b0;
      req_valid   <= 1'b0;
      stats_valid <= 1'b0;
    end else begin
      req_valid   <= rx.valid && rx.last && accept_now;
      stats_valid <= rx.valid && rx.last;
      if (rx.valid) begin
        hdr_ok <= hdr_ok_now;
        // clear on last so the next beat is offset 0
        if (rx.last) begin
          byte_cnt <= '0;
        end else begin
          byte_cnt <= len_now;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // field capture
  // ----------------------------------------------------------
  always_ff @(posedge gtx_clk_bufg) begin
    if (rx.valid) begin
      if (pos >= `OFS_SRC_MAC && pos < `OFS_SRC_MAC + 6) begin
        src_mac <= {src_mac[39:0], rx.data};
      end
      if (pos >= `OFS_SRC_IP && pos < `OFS_SRC_IP + 4) begin
        src_ip <= {src_ip[23:0], rx.data};
      end
      // x and y from the low bits of the first payload byte
      if (pos == `OFS_PAYLOAD) begin
        x_bit <= rx.data[0];
        y_bit <= rx.data[1];
      end
      if (rx.last) begin
        stats.len      <= len_now;
        stats.accepted <= accept_now;
        stats.is_short <= short_now;
      end
    end
  end

  // stable until the next frame reaches these offsets
  assign req.x   = x_bit;
  assign req.y   = y_bit;
  assign req.ip  = src_ip;
  assign req.mac = src_mac;

endmodule

// ==== verilog/stats_serializer.sv ====
/* Serialises each receive statistics word onto one pin, msb first, with a start
   bit before and a stop bit after; output idles low. */
`timescale 1ns/1ps
`include "accel_macros.svh"

module stats_serializer (
  input  logic               gtx_clk_bufg,
  input  logic               rst_n,
  input  logic               stats_valid,
  input  eth_pkg::rx_stats_t stats,
  output logic               rx_stats_serial
);

  // start bit, word, stop bit
  logic [`RX_STATS_BITS+1:0] shift;

  always_ff @(posedge gtx_clk_bufg) begin
    if (!rst_n) begin
      shift <= '0;
    end else if (stats_valid) begin
      // new word restarts the shifter at once
      shift <= {1'b1, stats, 1'b1};
    end else begin
      shift <= {shift[`RX_STATS_BITS:0], 1'b0};
    end
  end

  assign rx_stats_serial = shift[`RX_STATS_BITS+1];

endmodule

// ==== verilog/xor_net.sv ====
/* Two stage XOR network of threshold neurons. OR and NAND form the hidden layer,
   an AND neuron forms the output; result appears two cycles after the request. */
`timescale 1ns/1ps
`include "accel_macros.svh"

module xor_net (
  input  logic                  gtx_clk_bufg,
  input  logic                  rst_n,
  input  logic                  req_valid,
  input  accel_pkg::infer_req_t req,
  output logic                  res_valid,
  output accel_pkg::infer_res_t res
);

  // hidden layer registers
  logic               s1_valid;
  logic               h_or;
  logic               h_nand;
  eth_pkg::ip_addr_t  s1_ip;
  eth_pkg::mac_addr_t s1_mac;

  // weighted sum of two binary inputs, fires above zero
  function automatic logic neuron(
    input logic              a,
    input logic              b,
    input logic signed [5:0] w,
    input logic signed [5:0] bias
  );
    logic signed [5:0] sum;
    sum = bias + (a ? w : 6'sd0) + (b ? w : 6'sd0);
    return sum > 6'sd0;
  endfunction

  // valid pipe, one bit per stage
  always_ff @(posedge gtx_clk_bufg) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      s1_valid  <= req_valid;
      res_valid <= s1_valid;
    end
  end

  // ----------------------------------------------------------
  // stage one, hidden neurons
  // ----------------------------------------------------------
  always_ff @(posedge gtx_clk_bufg) begin
    h_or   <= neuron(req.x, req.y, `W_IN, `B_OR);
    h_nand <= neuron(req.x, req.y, -`W_IN, `B_NAND);
    s1_ip  <= req.ip;
    s1_mac <= req.mac;
  end

  // ----------------------------------------------------------
  // stage two, output neuron
  // ----------------------------------------------------------
  always_ff @(posedge gtx_clk_bufg) begin
    res.result <= neuron(h_or, h_nand, `W_HID, `B_OUT);
    res.ip     <= s1_ip;
    res.mac    <= s1_mac;
  end

endmodule
